//--- compile.f
+incdir+common
common/adc_pkg.sv
design/adc_ctrl_decode.sv
wallace_adder/tdc_partial_sum.sv
wallace_adder/adder_final_sum.sv
design/adc_slice_digital.sv
verif/adc_slice_assertions.sv
verif/tb_adc_slice.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build tb_adc_slice with Verilator, run it and check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module tb_adc_slice -f compile.f -o tb_adc_slice
	./obj_dir/tb_adc_slice +verilator+error+limit+1000 > $(LOG) 2>&1 \
		|| echo "=== FAIL ===" >> $(LOG)
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation failed"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- verif/tb_adc_slice.sv
// ADC slice testbench
`timescale 1ns/1ns

module tb_adc_slice;

    localparam int WATCH_CODE  = 0;
    localparam int WATCH_PHASE = 1;
    localparam int WATCH_TRIM  = 2;
    localparam int WATCH_CLEAR = 3;

    logic                 clk_adder;
    logic                 rstb;
    adc_pkg::tdc_sample_t sample;
    adc_pkg::trim_bin_t   trim;
    logic                 en_tdc_phase_reverse;
    adc_pkg::trim_thm_t   trim_thm;
    logic                 clk_tdc_phase_reverse;
    adc_pkg::adc_code_t   adder_out;
    logic                 sign_out;

    logic [31:0] lfsr = 32'he8b0_0a01;
    int          tests_run;
    int          tests_failed;
    bit          timed_out;

    adc_slice_digital DUT (
        .clk_adder             (clk_adder),
        .rstb                  (rstb),
        .sample                (sample),
        .trim                  (trim),
        .en_tdc_phase_reverse  (en_tdc_phase_reverse),
        .trim_thm              (trim_thm),
        .clk_tdc_phase_reverse (clk_tdc_phase_reverse),
        .adder_out             (adder_out),
        .sign_out              (sign_out)
    );

    bind adc_slice_digital adc_slice_assertions u_assertions (
        .clk_adder             (clk_adder),
        .rstb                  (rstb),
        .sample                (sample),
        .trim                  (trim),
        .en_tdc_phase_reverse  (en_tdc_phase_reverse),
        .trim_thm              (trim_thm),
        .clk_tdc_phase_reverse (clk_tdc_phase_reverse),
        .adder_out             (adder_out),
        .sign_out              (sign_out)
    );

    initial begin
        clk_adder = 1'b0;
        forever #20 clk_adder = ~clk_adder;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    task automatic take_bits(input int count, output logic [254:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            bits[i] = lfsr[0];
        end
    endtask

    function automatic bit watch_met(input int kind, input logic [92:0] value);
        case (kind)
            WATCH_CODE:  return adder_out === value[7:0];
            WATCH_PHASE: return clk_tdc_phase_reverse === value[0];
            WATCH_TRIM:  return trim_thm === value;
            default:     return trim_thm === '0 && clk_tdc_phase_reverse === 1'b0 &&
                                adder_out === '0 && sign_out === 1'b0;
        endcase
    endfunction

    // outputs are looked at on the falling edge, away from the flops
    task automatic wait_until(input int kind, input logic [92:0] value, input string name);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk_adder);
            cycles++;
        end while (!watch_met(kind, value) && cycles < 10);
        if (!watch_met(kind, value)) begin
            $display("timeout: the outputs never settled during test %s", name);
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input string name, input int unsigned fails_before);
        int unsigned fails;
        @(negedge clk_adder);
        fails = DUT.u_assertions.fail_count - fails_before;
        tests_run++;
        if (fails != 0) begin
            tests_failed++;
            $display("[FAIL] %s: expected 0 assertion failures, actual %0d", name, fails);
        end else begin
            $display("[PASS] %s", name);
        end
    endtask

    task automatic reset_sequence();
        int unsigned start;
        start = DUT.u_assertions.fail_count;
        // busy inputs mean that zero outputs can only come from the reset
        @(posedge clk_adder);
        sample.word          <= '1;
        sample.sign          <= 1'b1;
        trim                 <= '1;
        en_tdc_phase_reverse <= 1'b1;
        @(posedge clk_adder);
        rstb <= 1'b1;
        wait_until(WATCH_CODE, 93'd255, "reset");
        wait_until(WATCH_TRIM, {93{1'b1}}, "reset");
        @(posedge clk_adder);
        sample               <= '0;
        trim                 <= '0;
        en_tdc_phase_reverse <= 1'b0;
        wait_until(WATCH_CLEAR, 93'd0, "reset");
        report_test("reset", start);
    endtask

    task automatic decode_sweep();
        int unsigned  start;
        logic [4:0]   codes [5];
        logic [254:0] bits;
        start = DUT.u_assertions.fail_count;
        codes = '{5'd0, 5'd1, 5'd15, 5'd30, 5'd31};
        for (int i = 0; i < 5; i++) begin
            @(posedge clk_adder);
            trim <= {codes[i], 5'd31 - codes[i], codes[(i + 2) % 5]};
        end
        for (int i = 0; i < 12; i++) begin
            take_bits(15, bits);
            @(posedge clk_adder);
            trim <= bits[14:0];
        end
        @(posedge clk_adder);
        trim <= '1;
        wait_until(WATCH_TRIM, {93{1'b1}}, "thermometer decode");
        report_test("thermometer decode", start);
    endtask

    task automatic count_patterns();
        int unsigned         start;
        logic [254:0]        bits;
        adc_pkg::tdc_word_t  words [$];
        start = DUT.u_assertions.fail_count;
        words.push_back('0);
        words.push_back('1);
        words.push_back(adc_pkg::tdc_word_t'(1));
        words.push_back(adc_pkg::tdc_word_t'(1) << 127);
        words.push_back(adc_pkg::tdc_word_t'(1) << 254);
        for (int i = 0; i < 8; i++) begin
            take_bits(255, bits);
            words.push_back(bits);
        end
        foreach (words[i]) begin
            @(posedge clk_adder);
            sample.word <= words[i];
            sample.sign <= 1'b0;
        end
        @(posedge clk_adder);
        sample.word <= '1;
        wait_until(WATCH_CODE, 93'd255, "count");
        report_test("count", start);
    endtask

    task automatic pipeline_stream();
        int unsigned  start;
        logic [254:0] bits;
        logic [254:0] sign_bits;
        start = DUT.u_assertions.fail_count;
        for (int i = 0; i < 40; i++) begin
            take_bits(255, bits);
            take_bits(1, sign_bits);
            @(posedge clk_adder);
            sample.word <= bits;
            sample.sign <= sign_bits[0];
        end
        @(posedge clk_adder);
        sample <= '0;
        wait_until(WATCH_CODE, 93'd0, "sign and pipelining");
        report_test("sign and pipelining", start);
    endtask

    task automatic phase_toggle();
        int unsigned start;
        int          holds [6];
        start = DUT.u_assertions.fail_count;
        holds = '{1, 1, 2, 3, 1, 4};
        for (int i = 0; i < 6; i++) begin
            @(posedge clk_adder);
            en_tdc_phase_reverse <= ~en_tdc_phase_reverse;
            repeat (holds[i] - 1) @(posedge clk_adder);
        end
        @(posedge clk_adder);
        en_tdc_phase_reverse <= 1'b1;
        wait_until(WATCH_PHASE, 93'd1, "phase reverse");
        // reset lands while the reverse clock is high
        @(posedge clk_adder);
        rstb <= 1'b0;
        wait_until(WATCH_CLEAR, 93'd0, "phase reverse");
        @(posedge clk_adder);
        rstb <= 1'b1;
        wait_until(WATCH_PHASE, 93'd1, "phase reverse");
        @(posedge clk_adder);
        en_tdc_phase_reverse <= 1'b0;
        wait_until(WATCH_PHASE, 93'd0, "phase reverse");
        report_test("phase reverse", start);
    endtask

    initial begin
        rstb                 = 1'b0;
        sample               = '0;
        trim                 = '0;
        en_tdc_phase_reverse = 1'b0;
        tests_run            = 0;
        tests_failed         = 0;
        timed_out            = 1'b0;
        reset_sequence();
        if (!timed_out) decode_sweep();
        if (!timed_out) count_patterns();
        if (!timed_out) pipeline_stream();
        if (!timed_out) phase_toggle();
        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (timed_out || tests_failed != 0) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

//--- verif/adc_slice_assertions.sv
// ADC slice checks
`timescale 1ns/1ns

module adc_slice_assertions (
    input logic                 clk_adder,
    input logic                 rstb,
    input adc_pkg::tdc_sample_t sample,
    input adc_pkg::trim_bin_t   trim,
    input logic                 en_tdc_phase_reverse,
    input adc_pkg::trim_thm_t   trim_thm,
    input logic                 clk_tdc_phase_reverse,
    input adc_pkg::adc_code_t   adder_out,
    input logic                 sign_out
);

    int unsigned fail_count = 0;
    logic [1:0]  hist_cnt;  // clean edges since reset went away, stops at 3

    // all bits below the code are set
    function automatic logic [30:0] thermo(input logic [4:0] code);
        logic [31:0] ones;
        ones = (32'd1 << code) - 32'd1;
        return ones[30:0];
    endfunction

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            hist_cnt <= '0;
        end else if (hist_cnt != 2'd3) begin
            hist_cnt <= hist_cnt + 2'd1;
        end
    end

    // held in reset, and still clear on the first edge after release
    reset_clear: assert property (@(posedge clk_adder)
        ((!rstb && !$past(rstb)) || $rose(rstb)) |->
            (trim_thm == '0 && !clk_tdc_phase_reverse && adder_out == '0 && !sign_out))
        else begin
            $error("outputs not cleared by reset, adder_out %0d trim_thm %h", adder_out, trim_thm);
            fail_count++;
        end

    trim_decode: assert property (@(posedge clk_adder) disable iff (!rstb)
        hist_cnt >= 2'd1 |-> trim_thm ==
            {thermo($past(trim.v2t_n)), thermo($past(trim.v2t_p)), thermo($past(trim.dcdl))})
        else begin
            $error("trim_thm %h is not the decode of the previous trim", trim_thm);
            fail_count++;
        end

    count_ones: assert property (@(posedge clk_adder) disable iff (!rstb)
        hist_cnt >= 2'd2 |->
            adder_out == adc_pkg::adc_code_t'($countones($past(sample.word, 2))))
        else begin
            $error("adder_out %0d is not the ones count of the sample two cycles back", adder_out);
            fail_count++;
        end

    full_scale: assert property (@(posedge clk_adder) disable iff (!rstb)
        (hist_cnt >= 2'd2 && $past(sample.word, 2) == '1) |-> adder_out == 8'd255)
        else begin
            $error("all ones word gave adder_out %0d", adder_out);
            fail_count++;
        end

    sign_follow: assert property (@(posedge clk_adder) disable iff (!rstb)
        hist_cnt >= 2'd2 |-> sign_out == $past(sample.sign, 2))
        else begin
            $error("sign_out %b belongs to another sample", sign_out);
            fail_count++;
        end

    phase_delay: assert property (@(posedge clk_adder) disable iff (!rstb)
        hist_cnt >= 2'd2 |-> clk_tdc_phase_reverse == $past(en_tdc_phase_reverse, 2))
        else begin
            $error("clk_tdc_phase_reverse %b is not the enable from two cycles back",
                   clk_tdc_phase_reverse);
            fail_count++;
        end

endmodule

//--- design/adc_slice_digital.sv
// ADC slice digital back end
`timescale 1ns/1ns

module adc_slice_digital (
    input  logic                 clk_adder,
    input  logic                 rstb,
    input  adc_pkg::tdc_sample_t sample,
    input  adc_pkg::trim_bin_t   trim,
    input  logic                 en_tdc_phase_reverse,
    output adc_pkg::trim_thm_t   trim_thm,
    output logic                 clk_tdc_phase_reverse,
    output adc_pkg::adc_code_t   adder_out,
    output logic                 sign_out
);

    // execute to result bundle, one sample per cycle
    adc_pkg::psum_bundle_t psum;

    // trim controls for V2T and DCDL, plus the TDC reverse clock
    adc_ctrl_decode u_ctrl_decode (
        .clk_adder             (clk_adder),
        .rstb                  (rstb),
        .trim                  (trim),
        .en_tdc_phase_reverse  (en_tdc_phase_reverse),
        .trim_thm              (trim_thm),
        .clk_tdc_phase_reverse (clk_tdc_phase_reverse)
    );

    tdc_partial_sum u_partial_sum (
        .clk_adder (clk_adder),
        .rstb      (rstb),
        .sample    (sample),
        .psum      (psum)
    );

    // second pipeline stage, code leaves two cycles after the sample
    adder_final_sum u_final_sum (
        .clk_adder (clk_adder),
        .rstb      (rstb),
        .psum      (psum),
        .adder_out (adder_out),
        .sign_out  (sign_out)
    );

endmodule

//--- wallace_adder/adder_final_sum.sv
// TDC ones count, final stage
`timescale 1ns/1ns
`include "adc_macros.svh"

module adder_final_sum (
    input  logic                  clk_adder,
    input  logic                  rstb,
    input  adc_pkg::psum_bundle_t psum,
    output adc_pkg::adc_code_t    adder_out,
    output logic                  sign_out
);

    logic [`ADC_PSUM_W:0]     lvl1 [`ADC_NGROUP / 2];  // up to 32
    logic [`ADC_PSUM_W + 1:0] lvl2 [`ADC_NGROUP / 4];  // up to 64
    logic [`ADC_PSUM_W + 2:0] lvl3 [`ADC_NGROUP / 8];  // up to 128
    adc_pkg::adc_code_t       code_d;

    // balanced tree, one bit of growth per level
    always_comb begin
        for (int i = 0; i < `ADC_NGROUP / 2; i++) begin
            lvl1[i] = {1'b0, psum.sums[2 * i]} + {1'b0, psum.sums[2 * i + 1]};
        end
        for (int i = 0; i < `ADC_NGROUP / 4; i++) begin
            lvl2[i] = {1'b0, lvl1[2 * i]} + {1'b0, lvl1[2 * i + 1]};
        end
        for (int i = 0; i < `ADC_NGROUP / 8; i++) begin
            lvl3[i] = {1'b0, lvl2[2 * i]} + {1'b0, lvl2[2 * i + 1]};
        end
        // the full word holds at most 255 ones so the last add cannot overflow
        code_d = lvl3[0] + lvl3[1];
    end

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            adder_out <= '0;
            sign_out  <= 1'b0;
        end else begin
            adder_out <= code_d;
            sign_out  <= psum.sign;
        end
    end

endmodule

//--- wallace_adder/tdc_partial_sum.sv
// TDC ones count, first stage
`timescale 1ns/1ns
`include "adc_macros.svh"

module tdc_partial_sum (
    input  logic                  clk_adder,
    input  logic                  rstb,
    input  adc_pkg::tdc_sample_t  sample,
    output adc_pkg::psum_bundle_t psum
);

    logic [`ADC_GROUP_W * `ADC_NGROUP - 1:0] word_padded;
    adc_pkg::psum_bundle_t                    psum_d;

    // compressor tree over one 16 bit group, half adders then a 2, 3 and 4 bit layer
    function automatic adc_pkg::psum_t count_group(input logic [`ADC_GROUP_W - 1:0] bits);
        logic [1:0] lvl1 [`ADC_GROUP_W / 2];
        logic [2:0] lvl2 [`ADC_GROUP_W / 4];
        logic [3:0] lvl3 [`ADC_GROUP_W / 8];
        for (int i = 0; i < `ADC_GROUP_W / 2; i++) begin
            lvl1[i] = {1'b0, bits[2 * i]} + {1'b0, bits[2 * i + 1]};
        end
        for (int i = 0; i < `ADC_GROUP_W / 4; i++) begin
            lvl2[i] = {1'b0, lvl1[2 * i]} + {1'b0, lvl1[2 * i + 1]};
        end
        for (int i = 0; i < `ADC_GROUP_W / 8; i++) begin
            lvl3[i] = {1'b0, lvl2[2 * i]} + {1'b0, lvl2[2 * i + 1]};
        end
        return {1'b0, lvl3[0]} + {1'b0, lvl3[1]};
    endfunction

    // the chain has 255 stages so the top group gets one zero
    assign word_padded = {1'b0, sample.word};

    always_comb begin
        psum_d.sign = sample.sign;
        for (int g = 0; g < `ADC_NGROUP; g++) begin
            psum_d.sums[g] = count_group(word_padded[g * `ADC_GROUP_W +: `ADC_GROUP_W]);
        end
    end

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            psum <= '0;
        end else begin
            psum <= psum_d;  // sign rides with its own sums
        end
    end

endmodule

//--- design/adc_ctrl_decode.sv
// ADC trim decode
`timescale 1ns/1ns

module adc_ctrl_decode (
    input  logic                clk_adder,
    input  logic                rstb,
    input  adc_pkg::trim_bin_t  trim,
    input  logic                en_tdc_phase_reverse,
    output adc_pkg::trim_thm_t  trim_thm,
    output logic                clk_tdc_phase_reverse
);

    adc_pkg::trim_thm_t trim_thm_d;
    logic               en_phase_reverse_sampled;

    // bit i of the result is set when i is below the code
    function automatic adc_pkg::v2t_thm_t bin2thm(input adc_pkg::v2t_ctl_t code);
        adc_pkg::v2t_thm_t thm;
        for (int i = 0; i < $bits(adc_pkg::v2t_thm_t); i++) begin
            thm[i] = (i < int'(code));
        end
        return thm;
    endfunction

    // the DCDL code has the same widths as the V2T trim
    always_comb begin
        trim_thm_d.v2t_n = bin2thm(trim.v2t_n);
        trim_thm_d.v2t_p = bin2thm(trim.v2t_p);
        trim_thm_d.dcdl  = adc_pkg::dcdl_thm_t'(bin2thm(adc_pkg::v2t_ctl_t'(trim.dcdl)));
    end

    // registered so the analog loads see glitch free controls
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            trim_thm <= '0;
        end else begin
            trim_thm <= trim_thm_d;
        end
    end

    // two flops so the reverse clock only moves on a clk_adder edge
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            en_phase_reverse_sampled <= 1'b0;
            clk_tdc_phase_reverse    <= 1'b0;
        end else begin
            en_phase_reverse_sampled <= en_tdc_phase_reverse;
            clk_tdc_phase_reverse    <= en_phase_reverse_sampled;
        end
    end

endmodule

//--- common/adc_pkg.sv
// ADC slice types
`include "adc_macros.svh"

package adc_pkg;

    // one bit per TDC delay stage
    typedef logic [(2 ** `ADC_NADC) - 2:0] tdc_word_t;
    typedef logic [`ADC_NADC - 1:0] adc_code_t;

    typedef logic [`ADC_NCTL_V2T - 1:0] v2t_ctl_t;
    typedef logic [(2 ** `ADC_NCTL_V2T) - 2:0] v2t_thm_t;
    typedef logic [`ADC_NCTL_TDC - 1:0] dcdl_ctl_t;
    typedef logic [(2 ** `ADC_NCTL_TDC) - 2:0] dcdl_thm_t;

    typedef logic [`ADC_PSUM_W - 1:0] psum_t;

    typedef struct packed {
        tdc_word_t word;
        logic      sign;  // PFD decision for the same conversion
    } tdc_sample_t;

    typedef struct packed {
        psum_t [`ADC_NGROUP - 1:0] sums;
        logic                      sign;
    } psum_bundle_t;

    typedef struct packed {
        v2t_ctl_t  v2t_n;
        v2t_ctl_t  v2t_p;
        dcdl_ctl_t dcdl;
    } trim_bin_t;

    typedef struct packed {
        v2t_thm_t  v2t_n;
        v2t_thm_t  v2t_p;
        dcdl_thm_t dcdl;
    } trim_thm_t;

endpackage

//--- common/adc_macros.svh
// ADC slice widths
`ifndef ADC_MACROS_SVH
`define ADC_MACROS_SVH

// output code width, the TDC chain has 2**ADC_NADC-1 stages
`define ADC_NADC 8

// binary trim code width of each V2T
`define ADC_NCTL_V2T 5

// binary code width of the coarse DCDL
`define ADC_NCTL_TDC 5

// the TDC word is counted in groups of this many bits
`define ADC_GROUP_W 16
`define ADC_NGROUP 16

// ones count of one group, 0 to 16
`define ADC_PSUM_W 5

`endif
